/* logic/div_config.svh */
`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// Operand and result width in bits
`define DIV_WIDTH 8

// Queue depths must be powers of two
`define CMD_DEPTH 4
`define RES_DEPTH 4

`endif

/* logic/div_pkg.sv */
`default_nettype none

`include "div_config.svh"

package div_pkg;

    typedef logic [`DIV_WIDTH-1:0] word_t;  // Unsigned operand or result

    // One queued division request
    typedef struct packed {
        word_t dividend;
        word_t divisor;
    } cmd_t;

    // One finished division
    typedef struct packed {
        word_t quotient;
        word_t remainder;
        logic  error;      // Divide by zero
    } res_t;

endpackage

`default_nettype wire

/* logic/sync_queue.sv */
`default_nettype none

module sync_queue #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  wire      clk,
    input  wire      rst_n,
    input  wire      push,
    input  wire      payload_t push_data,
    input  wire      pop,
    output payload_t head,
    output logic     empty,
    output logic     full
);

    localparam int AW = $clog2(DEPTH);

    payload_t      mem [DEPTH];
    logic [AW:0]   wr_ptr;     // Extra MSB tells full from empty
    logic [AW:0]   rd_ptr;
    logic          do_push;
    logic          do_pop;

    if (DEPTH < 2 || (DEPTH & (DEPTH - 1)) != 0) begin : g_bad_depth
        $error("sync_queue DEPTH must be a power of two of at least 2");
    end

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                   (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_push = push && !full;    // Ignored when full
    assign do_pop  = pop && !empty;

    // First word falls through to the head
    assign head = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage array
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_data;
        end
    end

    // Producer must respect full, consumer must respect empty
    assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
        else $error("sync_queue: push while full");

    assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
        else $error("sync_queue: pop while empty");

endmodule

`default_nettype wire

/* logic/div_engine.sv */
`default_nettype none

`include "div_config.svh"

module div_engine (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            start,
    input  wire            div_pkg::word_t dividend,
    input  wire            div_pkg::word_t divisor,
    output logic           busy,
    output logic           done,
    output div_pkg::word_t quotient,
    output div_pkg::word_t remainder,
    output logic           error
);
    import div_pkg::*;

    localparam int W  = `DIV_WIDTH;
    localparam int CW = $clog2(W + 1);

    logic [CW-1:0] count;   // Dividend bits still to bring down
    word_t         dvd;     // Shifts out MSB first
    word_t         dvs;
    word_t         rem;     // Partial remainder
    word_t         quo;     // Quotient being built
    logic [W:0]    trial;
    logic          fits;

    // Shifted remainder needs one bit more than a word
    assign trial = {rem, dvd[W-1]};
    assign fits  = (trial >= {1'b0, dvs});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            error <= 1'b0;
            count <= '0;
        end else begin
            done <= 1'b0;                       // Single cycle pulse
            if (!busy) begin
                if (start) begin
                    if (divisor == '0) begin
                        done  <= 1'b1;          // Answer right away
                        error <= 1'b1;
                    end else begin
                        busy  <= 1'b1;
                        error <= 1'b0;
                        count <= CW'(W);
                    end
                end
            end else if (count != '0) begin
                count <= count - 1'b1;
            end else begin
                // Publish and return to idle
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            dvd <= dividend;
            dvs <= divisor;
            rem <= '0;
            quo <= '0;
            if (divisor == '0) begin
                quotient  <= '0;
                remainder <= '0;
            end
        end else if (busy) begin
            if (count != '0) begin
                dvd <= dvd << 1;
                quo <= {quo[W-2:0], fits};
                rem <= fits ? W'(trial - {1'b0, dvs}) : trial[W-1:0];
            end else begin
                quotient  <= quo;                // Held until next start
                remainder <= rem;
            end
        end
    end

    // The sequencer must wait for idle before starting again
    assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy)
        else $error("div_engine: start while busy");

endmodule

`default_nettype wire

/* logic/div_sequencer.sv */
`default_nettype none

module div_sequencer (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            div_pkg::cmd_t cmd_head,
    input  wire            cmd_empty,
    input  wire            res_full,
    input  wire            eng_busy,
    input  wire            eng_done,
    input  wire            div_pkg::word_t eng_quotient,
    input  wire            div_pkg::word_t eng_remainder,
    input  wire            eng_error,
    output logic           cmd_pop,
    output logic           eng_start,
    output div_pkg::word_t eng_dividend,
    output div_pkg::word_t eng_divisor,
    output logic           res_push,
    output div_pkg::res_t  res_data
);
    import div_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_RUN, S_HOLD} state_t;

    state_t state;
    res_t   eng_res;
    res_t   held;        // Result parked while result queue is full
    logic   launch;

    assign eng_res = '{quotient: eng_quotient, remainder: eng_remainder, error: eng_error};

    // Work waiting, engine free, nothing parked
    assign launch = (state == S_IDLE) && !cmd_empty && !eng_busy;

    assign res_push = !res_full && ((state == S_RUN && eng_done) || state == S_HOLD);
    assign res_data = (state == S_HOLD) ? held : eng_res;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            cmd_pop   <= 1'b0;
            eng_start <= 1'b0;
        end else begin
            cmd_pop   <= launch;    // Pop lines up with start
            eng_start <= launch;
            case (state)
                S_IDLE: begin
                    if (launch) begin
                        state <= S_RUN;
                    end
                end
                S_RUN: begin
                    if (eng_done) begin
                        state <= res_full ? S_HOLD : S_IDLE;
                    end
                end
                S_HOLD: begin
                    if (!res_full) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            eng_dividend <= cmd_head.dividend;
            eng_divisor  <= cmd_head.divisor;
        end
        if (state == S_RUN && eng_done) begin
            held <= eng_res;
        end
    end

    // Engine either starts running or answers a zero divisor at once
    assert property (@(posedge clk) disable iff (!rst_n)
                     eng_start |=> (eng_busy || eng_done))
        else $error("div_sequencer: engine ignored start");

endmodule

`default_nettype wire

/* logic/div_unit.sv */
`default_nettype none

`include "div_config.svh"

module div_unit (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            cmd_push,
    input  wire            div_pkg::word_t cmd_dividend,
    input  wire            div_pkg::word_t cmd_divisor,
    output logic           cmd_full,
    input  wire            res_pop,
    output logic           res_empty,
    output div_pkg::word_t res_quotient,
    output div_pkg::word_t res_remainder,
    output logic           res_error
);
    import div_pkg::*;

    cmd_t  cmd_in;
    cmd_t  cmd_head;
    logic  cmd_empty;
    logic  cmd_pop;
    res_t  res_in;
    res_t  res_head;
    logic  res_full;
    logic  res_push;
    logic  eng_start;
    logic  eng_busy;
    logic  eng_done;
    logic  eng_error;
    word_t eng_dividend;
    word_t eng_divisor;
    word_t eng_quotient;
    word_t eng_remainder;

    assign cmd_in = '{dividend: cmd_dividend, divisor: cmd_divisor};

    // Head of result queue straight to the host
    assign res_quotient  = res_head.quotient;
    assign res_remainder = res_head.remainder;
    assign res_error     = res_head.error;

    sync_queue #(.payload_t(cmd_t), .DEPTH(`CMD_DEPTH)) cmd_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (cmd_push),
        .push_data (cmd_in),
        .pop       (cmd_pop),
        .head      (cmd_head),
        .empty     (cmd_empty),
        .full      (cmd_full)
    );

    div_sequencer sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_head      (cmd_head),
        .cmd_empty     (cmd_empty),
        .res_full      (res_full),
        .eng_busy      (eng_busy),
        .eng_done      (eng_done),
        .eng_quotient  (eng_quotient),
        .eng_remainder (eng_remainder),
        .eng_error     (eng_error),
        .cmd_pop       (cmd_pop),
        .eng_start     (eng_start),
        .eng_dividend  (eng_dividend),
        .eng_divisor   (eng_divisor),
        .res_push      (res_push),
        .res_data      (res_in)
    );

    div_engine engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (eng_start),
        .dividend  (eng_dividend),
        .divisor   (eng_divisor),
        .busy      (eng_busy),
        .done      (eng_done),
        .quotient  (eng_quotient),
        .remainder (eng_remainder),
        .error     (eng_error)
    );

    sync_queue #(.payload_t(res_t), .DEPTH(`RES_DEPTH)) res_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (res_push),
        .push_data (res_in),
        .pop       (res_pop),
        .head      (res_head),
        .empty     (res_empty),
        .full      (res_full)
    );

endmodule

`default_nettype wire

/* bench/div_unit_tb.sv */
`default_nettype none

`include "div_config.svh"

module div_unit_tb;

    localparam int W       = `DIV_WIDTH;
    localparam int ROWS    = 24;
    localparam int PERIOD  = 8;
    localparam int BP_MAX  = `CMD_DEPTH + `RES_DEPTH + 2;
    localparam int TIMEOUT = ROWS * (W + 8) * PERIOD * 4;
    localparam logic [W-1:0] ONES = '1;

    logic         clk;
    logic         rst_n;
    logic         cmd_push;
    logic [W-1:0] cmd_dividend;
    logic [W-1:0] cmd_divisor;
    logic         cmd_full;
    logic         res_pop;
    logic         res_empty;
    logic [W-1:0] res_quotient;
    logic [W-1:0] res_remainder;
    logic         res_error;

    string        tab_name [ROWS];
    logic [W-1:0] tab_a [ROWS];    // Dividend
    logic [W-1:0] tab_b [ROWS];    // Divisor
    int           sent [$];        // Rows accepted in push order
    int           errors;
    int           checked;
    int           accepted;
    int           rose_at;
    int           high_run;
    logic [31:0]  rng;

    div_unit uut (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout at %0t: the results did not all arrive", $time);
        $display("TEST FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic set_row(input int i, input string name, input logic [W-1:0] a, b);
        tab_name[i] = name;
        tab_a[i]    = a;
        tab_b[i]    = b;
    endtask

    task automatic build_table();
        set_row(0, "zero_divisor", W'(37), '0);
        set_row(1, "zero_over_zero", '0, '0);
        set_row(2, "ones_over_zero", ONES, '0);
        set_row(3, "divisor_one", W'(200), W'(1));
        set_row(4, "ones_over_one", ONES, W'(1));
        set_row(5, "dividend_small", W'(3), W'(7));
        set_row(6, "zero_dividend", '0, W'(9));
        set_row(7, "all_ones", ONES, ONES);
        set_row(8, "equal_operands", W'(100), W'(100));
        set_row(9, "ones_over_two", ONES, W'(2));
        for (int i = 10; i < ROWS; i++) begin
            rng = xorshift(rng);
            tab_a[i] = rng[W-1:0];
            rng = xorshift(rng);
            set_row(i, $sformatf("random_%0d", i), tab_a[i], rng[W-1:0]);
        end
    endtask

    // Row goes in at the next rising edge
    task automatic drive_row(input int idx);
        cmd_push     = 1'b1;
        cmd_dividend = tab_a[idx];
        cmd_divisor  = tab_b[idx];
        sent.push_back(idx);
    endtask

    task automatic check_head();
        int           idx;
        logic [W-1:0] exp_q;
        logic [W-1:0] exp_r;
        logic         exp_e;
        if (sent.size() == 0) begin
            $display("ERROR: a result came out with no command outstanding");
            errors++;
        end else begin
            idx     = sent.pop_front();
            checked++;
            exp_e   = (tab_b[idx] == '0);
            exp_q   = '0;
            exp_r   = '0;
            if (!exp_e) begin
                exp_q = tab_a[idx] / tab_b[idx];
                exp_r = tab_a[idx] % tab_b[idx];
            end
            if (res_quotient !== exp_q) begin
                $display("MISMATCH %s quotient: expected %0d, actual %0d",
                         tab_name[idx], exp_q, res_quotient);
                errors++;
            end
            if (res_remainder !== exp_r) begin
                $display("MISMATCH %s remainder: expected %0d, actual %0d",
                         tab_name[idx], exp_r, res_remainder);
                errors++;
            end
            if (res_error !== exp_e) begin
                $display("MISMATCH %s error: expected %b, actual %b",
                         tab_name[idx], exp_e, res_error);
                errors++;
            end
        end
    endtask

    task automatic pop_results(input int count);
        int got;
        got = 0;
        while (got < count) begin
            @(negedge clk);
            res_pop = 1'b0;
            if (!res_empty) begin
                check_head();
                res_pop = 1'b1;    // Head leaves at the next edge
                got++;
            end
        end
        @(negedge clk);
        res_pop = 1'b0;
    endtask

    task automatic push_rows();
        int idx;
        idx = 0;
        while (idx < ROWS) begin
            @(negedge clk);
            cmd_push = 1'b0;
            rng      = xorshift(rng);
            if (!cmd_full && rng[1:0] != 2'b00) begin    // Random gaps
                drive_row(idx);
                idx++;
            end
        end
        @(negedge clk);
        cmd_push = 1'b0;
    endtask

    initial begin
        rst_n        = 1'b0;
        cmd_push     = 1'b0;
        cmd_dividend = '0;
        cmd_divisor  = '0;
        res_pop      = 1'b0;
        errors       = 0;
        checked      = 0;
        rng          = 32'hd115;
        build_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (res_empty !== 1'b1) begin
            $display("MISMATCH reset res_empty: expected 1, actual %b", res_empty);
            errors++;
        end
        if (cmd_full !== 1'b0) begin
            $display("MISMATCH reset cmd_full: expected 0, actual %b", cmd_full);
            errors++;
        end

        // Host pushes and pops in the same cycles
        fork
            push_rows();
            pop_results(ROWS);
        join

        // No pops until the command queue stays full
        accepted = 0;
        high_run = 0;
        rose_at  = -1;
        while (high_run < 40) begin
            @(negedge clk);
            cmd_push = 1'b0;
            if (!cmd_full) begin
                drive_row(accepted % ROWS);
                accepted++;
                high_run = 0;
            end else begin
                high_run++;
                if (rose_at < 0) begin
                    rose_at = accepted;
                end
            end
        end
        if (rose_at > BP_MAX || accepted > BP_MAX) begin
            $display("ERROR: cmd_full first rose after %0d pushes, %0d accepted, limit %0d",
                     rose_at, accepted, BP_MAX);
            errors++;
        end
        pop_results(accepted);

        repeat (2 * (W + 8)) @(negedge clk);
        if (!res_empty) begin
            $display("ERROR: an extra result came out after every row was answered");
            errors++;
        end
        $display("Finished with %0d errors over %0d results", errors, checked);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+logic
logic/div_pkg.sv
logic/sync_queue.sv
logic/div_engine.sv
logic/div_sequencer.sv
logic/div_unit.sv
bench/div_unit_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = div_unit_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
